// File: Bender.yml
package:
  name: mist_io_lite

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mist_io_pkg.sv
      - rtl/spi_frame_rx.sv
      - rtl/io_cmd_exec.sv
      - rtl/spi_reply_tx.sv
      - rtl/ioctl_xfer.sv
      - rtl/mist_io_lite.sv
  - target: simulation
    include_dirs:
      - rtl
      - dv
    files:
      - dv/tb_mist_io.sv

// File: dv/tb_spi_tasks.svh
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// SCK half period in clk_sys cycles
`define TB_SCK_HALF 4
// longest wait for any DUT response, clk_sys cycles
`define TB_WAIT_CYC 200

// all stimulus moves on the falling clk_sys edge
task automatic clk_fall(input int n);
	repeat (n) @(negedge clk_sys);
endtask

// one byte msb first, SCK idles low
// DO read right before the rising SCK edge, like the master sampling it
task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
	int i;
	for (i = 7; i >= 0; i--) begin
		SPI_DI = tx[i];
		clk_fall(`TB_SCK_HALF);
		rx[i] = SPI_DO;
		SPI_SCK = 1'b1;
		clk_fall(`TB_SCK_HALF);
		SPI_SCK = 1'b0;
	end
endtask

// sends tx_q as one frame, reply bytes land in rx_q
task automatic spi_frame();
	logic [7:0] rx;
	int k;
	rx_q.delete();
	SPI_SS2 = 1'b0;
	clk_fall(`TB_SCK_HALF);
	for (k = 0; k < tx_q.size(); k++) begin
		spi_byte(tx_q[k], rx);
		rx_q.push_back(rx);
	end
	clk_fall(`TB_SCK_HALF);
	SPI_SS2 = 1'b1;
	clk_fall(2 * `TB_SCK_HALF);
endtask

// bounded wait until n ioctl writes are logged
task automatic wait_writes(input int n);
	int cnt;
	cnt = 0;
	checks++;
	while ((wr_data_q.size() < n) && (cnt < `TB_WAIT_CYC)) begin
		@(negedge clk_sys);
		cnt++;
	end
	assert (wr_data_q.size() >= n) else
		note_fail($sformatf("timed out waiting for %0d ioctl writes", n));
endtask

// bounded wait for the download level
task automatic wait_download(input logic level);
	int cnt;
	cnt = 0;
	checks++;
	while ((ioctl_download !== level) && (cnt < `TB_WAIT_CYC)) begin
		@(negedge clk_sys);
		cnt++;
	end
	assert (ioctl_download === level) else
		note_fail($sformatf("ioctl_download never went to %b", level));
endtask

`endif

// File: dv/tb_mist_io.sv
`timescale 1ns/1ps

`include "mist_io_settings.svh"

module tb_mist_io;

	logic                      clk_sys;
	logic                      SPI_SCK;
	logic                      SPI_SS2;
	logic                      SPI_DI;
	wire                       SPI_DO;
	logic [`MIST_CONF_W-1:0]   conf_str;
	logic [7:0]                data_in;
	logic [`MIST_STATUS_W-1:0] status;
	logic                      ioctl_ce;
	logic                      ioctl_download;
	logic                      ioctl_wr;
	logic [`MIST_IOCTL_AW-1:0] ioctl_addr;
	logic [7:0]                ioctl_dout;

	// frame bytes out and reply bytes back
	logic [7:0] tx_q[$];
	logic [7:0] rx_q[$];
	// every ioctl write seen
	logic [`MIST_IOCTL_AW-1:0] wr_addr_q[$];
	logic [7:0]                wr_data_q[$];

	string test_name;
	// config text, first character is sent first
	string conf_text;
	int    test_errs;
	int    errors;
	int    checks;
	int    tests;

	mist_io_lite dut0 (
		.clk_sys        (clk_sys),
		.SPI_SCK        (SPI_SCK),
		.SPI_SS2        (SPI_SS2),
		.SPI_DI         (SPI_DI),
		.SPI_DO         (SPI_DO),
		.conf_str       (conf_str),
		.data_in        (data_in),
		.status         (status),
		.ioctl_ce       (ioctl_ce),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ioctl outputs only move on the rising edge
	always @(negedge clk_sys) begin
		if (ioctl_wr === 1'b1) begin
			wr_addr_q.push_back(ioctl_addr);
			wr_data_q.push_back(ioctl_dout);
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		tests++;
		$display("test %s finished, %0d errors", test_name, test_errs);
	endtask

	task automatic note_fail(input string msg);
		errors++;
		test_errs++;
		$display("%s: %s", test_name, msg);
	endtask

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			test_errs++;
			$display("error %s (%s): expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_true(input string what, input logic cond);
		checks++;
		assert (cond === 1'b1) else
			note_fail(what);
	endtask

	`include "tb_spi_tasks.svh"

	initial begin
		int unsigned seed_ret;
		logic [7:0] sbytes [4];
		logic [31:0] exp_status;
		logic [`MIST_IOCTL_AW-1:0] exp_addr;
		logic [7:0] pump_byte;
		int n;
		int k;

		seed_ret = $urandom(32'h4b30_bc68);
		SPI_SS2  = 1'b0;
		SPI_SCK  = 1'b0;
		SPI_DI   = 1'b0;
		ioctl_ce = 1'b1;
		data_in  = 8'h00;
		conf_text = "MISTIO;LITE1";
		conf_str = '0;
		for (k = 0; k < `MIST_CONF_STRLEN; k++) begin
			conf_str[8*(`MIST_CONF_STRLEN-1-k) +: 8] = conf_text[k];
		end
		// select rises on the first falling clock edge and resets the SPI side
		clk_fall(1);
		SPI_SS2 = 1'b1;
		// deselected frame doubles as reset
		clk_fall(4);

		start_test("power_up");
		check_val("ioctl_wr", 0, ioctl_wr);
		check_val("ioctl_download", 0, ioctl_download);
		check_val("status", 0, status);
		check_true("SPI_DO driven while deselected", SPI_DO === 1'bz);
		finish_test();

		start_test("ack");
		tx_q = {mist_io_pkg::CMD_ACK, 8'h00};
		spi_frame();
		check_val("reply byte 1", `MIST_ACK_BYTE, rx_q[1]);
		finish_test();

		start_test("read_data");
		data_in = $urandom;
		tx_q = {mist_io_pkg::CMD_READ_DATA, 8'h00};
		spi_frame();
		check_val("reply byte 1", data_in, rx_q[1]);
		finish_test();

		// two bytes past the string read back as zero
		start_test("conf_str");
		tx_q = {mist_io_pkg::CMD_CONF_STR};
		for (k = 0; k < `MIST_CONF_STRLEN + 2; k++) begin
			tx_q.push_back(8'h00);
		end
		spi_frame();
		for (k = 1; k <= `MIST_CONF_STRLEN + 2; k++) begin
			check_val($sformatf("reply byte %0d", k),
				(k <= `MIST_CONF_STRLEN) ? conf_text[k-1] : 8'h00, rx_q[k]);
		end
		finish_test();

		start_test("status");
		tx_q = {mist_io_pkg::CMD_STATUS};
		for (k = 0; k < 4; k++) begin
			sbytes[k] = $urandom;
			tx_q.push_back(sbytes[k]);
		end
		exp_status = {sbytes[0], sbytes[1], sbytes[2], sbytes[3]};
		spi_frame();
		check_val("status after write", exp_status, status);
		// other command, data bytes must not touch status
		tx_q = {mist_io_pkg::CMD_ACK, 8'($urandom), 8'($urandom)};
		spi_frame();
		check_val("status kept", exp_status, status);
		finish_test();

		start_test("download");
		n = 4 + ($urandom % 5);
		exp_addr = `MIST_DL_BASE_ADDR;
		tx_q = {mist_io_pkg::CMD_DL_BASE, 8'($urandom)};
		spi_frame();
		check_val("ioctl_download before start", 0, ioctl_download);
		wr_addr_q.delete();
		wr_data_q.delete();
		tx_q = {mist_io_pkg::CMD_DL_START};
		for (k = 0; k < n; k++) begin
			tx_q.push_back(8'($urandom));
		end
		spi_frame();
		wait_download(1'b1);
		wait_writes(n);
		clk_fall(8);
		check_val("write count", n, wr_data_q.size());
		for (k = 0; k < n && k < wr_data_q.size(); k++) begin
			check_val($sformatf("addr %0d", k), exp_addr + k, wr_addr_q[k]);
			check_val($sformatf("data %0d", k), tx_q[k+1], wr_data_q[k]);
		end
		exp_addr = exp_addr + n;
		tx_q = {mist_io_pkg::CMD_DL_END};
		spi_frame();
		wait_download(1'b0);
		finish_test();

		// address carries on from the last download
		start_test("ce_low");
		ioctl_ce = 1'b0;
		wr_addr_q.delete();
		wr_data_q.delete();
		pump_byte = $urandom;
		tx_q = {mist_io_pkg::CMD_DL_START, pump_byte};
		spi_frame();
		clk_fall(16);
		check_val("writes with ce low", 0, wr_data_q.size());
		ioctl_ce = 1'b1;
		wait_writes(1);
		clk_fall(8);
		check_val("write count", 1, wr_data_q.size());
		if (wr_data_q.size() > 0) begin
			check_val("addr", exp_addr, wr_addr_q[0]);
			check_val("data", pump_byte, wr_data_q[0]);
		end
		tx_q = {mist_io_pkg::CMD_DL_END};
		spi_frame();
		wait_download(1'b0);
		finish_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+rtl
+incdir+dv
rtl/mist_io_pkg.sv
rtl/spi_frame_rx.sv
rtl/io_cmd_exec.sv
rtl/spi_reply_tx.sv
rtl/ioctl_xfer.sv
rtl/mist_io_lite.sv
dv/tb_mist_io.sv

// File: rtl/io_cmd_exec.sv
`timescale 1ns/1ps

`include "mist_io_settings.svh"

module io_cmd_exec (
	input  logic                      SPI_SCK,
	input  logic                      SPI_SS2,
	input  mist_io_pkg::spi_byte_t    rx_byte,
	output mist_io_pkg::io_cmd_e      cmd,
	output logic [`MIST_STATUS_W-1:0] status,
	output mist_io_pkg::dl_word_t     dl_word,
	output logic                      dl_toggle,
	output logic                      dl_active
);

	// command of the current frame
	mist_io_pkg::io_cmd_e cmd_q;
	// incoming byte viewed as a command
	mist_io_pkg::io_cmd_e rx_cmd;

	// data byte number in this frame, 0 is the first after the command
	logic [`MIST_DATA_IDX_W-1:0] data_idx;
	logic                        data_strb;

	// kept across frames, zero after power-up
	logic [`MIST_STATUS_W-1:0] status_q    = '0;
	logic [`MIST_IOCTL_AW-1:0] dl_addr     = '0;
	logic                      dl_toggle_q = 1'b0;
	logic                      dl_active_q = 1'b0;

	// last pumped byte, read in clk_sys after the toggle flips
	mist_io_pkg::dl_word_t dl_word_q;

	assign rx_cmd    = mist_io_pkg::io_cmd_e'(rx_byte.data);
	assign data_strb = rx_byte.strb & ~rx_byte.is_cmd;

	// per-frame state, cleared while not selected
	always_ff @(posedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2) begin
			cmd_q    <= mist_io_pkg::CMD_ACK;
			data_idx <= '0;
		end else if (rx_byte.strb) begin
			if (rx_byte.is_cmd) begin
				cmd_q <= rx_cmd;
			end else if (data_idx != `MIST_DATA_IDX_MAX) begin
				// stop counting once past the status bytes
				data_idx <= data_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge SPI_SCK) begin
		// download level follows the start and end commands directly
		if (rx_byte.strb && rx_byte.is_cmd) begin
			if (rx_cmd == mist_io_pkg::CMD_DL_START) begin
				dl_active_q <= 1'b1;
			end
			if (rx_cmd == mist_io_pkg::CMD_DL_END) begin
				dl_active_q <= 1'b0;
			end
		end

		if (data_strb) begin
			case (cmd_q)
				mist_io_pkg::CMD_STATUS: begin
					// top byte comes first, bytes after the fourth are dropped
					case (data_idx)
						3'd0: status_q[31:24] <= rx_byte.data;
						3'd1: status_q[23:16] <= rx_byte.data;
						3'd2: status_q[15:8]  <= rx_byte.data;
						3'd3: status_q[7:0]   <= rx_byte.data;
						default: ;
					endcase
				end
				mist_io_pkg::CMD_DL_BASE: begin
					if (data_idx == '0) begin
						dl_addr <= `MIST_DL_BASE_ADDR;
					end
				end
				mist_io_pkg::CMD_DL_START: begin
					// word is settled before the toggle is seen in clk_sys
					dl_word_q.addr <= dl_addr;
					dl_word_q.data <= rx_byte.data;
					dl_addr        <= dl_addr + 1'b1;
					dl_toggle_q    <= ~dl_toggle_q;
				end
				default: ;
			endcase
		end
	end

	assign cmd       = cmd_q;
	assign status    = status_q;
	assign dl_word   = dl_word_q;
	assign dl_toggle = dl_toggle_q;
	assign dl_active = dl_active_q;

endmodule

// File: rtl/ioctl_xfer.sv
`timescale 1ns/1ps

`include "mist_io_settings.svh"

module ioctl_xfer (
	input  logic                      clk_sys,
	input  logic                      ioctl_ce,
	input  mist_io_pkg::dl_word_t     dl_word,
	input  logic                      dl_toggle,
	input  logic                      dl_active,
	output logic                      ioctl_download,
	output logic                      ioctl_wr,
	output logic [`MIST_IOCTL_AW-1:0] ioctl_addr,
	output logic [7:0]                ioctl_dout
);

	// toggle synchronizer, [0] first stage
	logic [1:0] tog_s = 2'b00;
	// first stage for the download level
	logic       act_s = 1'b0;

	logic dl_wr_q    = 1'b0;
	logic dl_level_q = 1'b0;

	// word copied on the toggle edge
	mist_io_pkg::dl_word_t out_q;

	// everything advances only on clock enable
	// so several flips during a low enable collapse into one
	always_ff @(posedge clk_sys) begin
		if (ioctl_ce) begin
			tog_s      <= {tog_s[0], dl_toggle};
			act_s      <= dl_active;
			dl_level_q <= act_s;
			dl_wr_q    <= 1'b0;
			// word was stable before the flip reached here
			if (tog_s[1] != tog_s[0]) begin
				out_q   <= dl_word;
				dl_wr_q <= 1'b1;
			end
		end
	end

	assign ioctl_download = dl_level_q;
	assign ioctl_wr       = dl_wr_q;
	assign ioctl_addr     = out_q.addr;
	assign ioctl_dout     = out_q.data;

endmodule

// File: rtl/mist_io_lite.sv
`timescale 1ns/1ps

`include "mist_io_settings.svh"

module mist_io_lite (
	input  logic                      clk_sys,
	input  logic                      SPI_SCK,
	input  logic                      SPI_SS2,
	input  logic                      SPI_DI,
	output logic                      SPI_DO,
	input  logic [`MIST_CONF_W-1:0]   conf_str,
	input  logic [7:0]                data_in,
	output logic [`MIST_STATUS_W-1:0] status,
	input  logic                      ioctl_ce,
	output logic                      ioctl_download,
	output logic                      ioctl_wr,
	output logic [`MIST_IOCTL_AW-1:0] ioctl_addr,
	output logic [7:0]                ioctl_dout
);

	// SCK rising domain
	mist_io_pkg::spi_byte_t rx_byte;
	mist_io_pkg::io_cmd_e   cmd;

	// crossing into clk_sys
	mist_io_pkg::dl_word_t dl_word;
	logic                  dl_toggle;
	logic                  dl_active;

	spi_frame_rx u_rx (
		.SPI_SCK (SPI_SCK),
		.SPI_SS2 (SPI_SS2),
		.SPI_DI  (SPI_DI),
		.rx_byte (rx_byte)
	);

	io_cmd_exec u_exec (
		.SPI_SCK   (SPI_SCK),
		.SPI_SS2   (SPI_SS2),
		.rx_byte   (rx_byte),
		.cmd       (cmd),
		.status    (status),
		.dl_word   (dl_word),
		.dl_toggle (dl_toggle),
		.dl_active (dl_active)
	);

	// reply side, falling edge
	spi_reply_tx u_tx (
		.SPI_SCK  (SPI_SCK),
		.SPI_SS2  (SPI_SS2),
		.cmd      (cmd),
		.data_in  (data_in),
		.conf_str (conf_str),
		.SPI_DO   (SPI_DO)
	);

	ioctl_xfer u_ioctl (
		.clk_sys        (clk_sys),
		.ioctl_ce       (ioctl_ce),
		.dl_word        (dl_word),
		.dl_toggle      (dl_toggle),
		.dl_active      (dl_active),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

// File: rtl/mist_io_pkg.sv
`include "mist_io_settings.svh"

package mist_io_pkg;

	// command byte codes sent by the io controller
	typedef enum logic [7:0] {
		// plain acknowledge, answers with the ack byte
		CMD_ACK       = 8'h00,
		// read back the data_in port
		CMD_READ_DATA = 8'h10,
		// read back the configuration string
		CMD_CONF_STR  = 8'h14,
		// write the 32-bit status word, top byte first
		CMD_STATUS    = 8'h15,
		// set the download address to the base
		CMD_DL_BASE   = 8'h60,
		// start download, every data byte gets pumped
		CMD_DL_START  = 8'h61,
		// end download
		CMD_DL_END    = 8'h62
	} io_cmd_e;

	// one byte off the serial line
	typedef struct packed {
		// high on the SCK edge that completes the byte
		logic       strb;
		// byte 0 of the frame
		logic       is_cmd;
		logic [7:0] data;
	} spi_byte_t;

	// one pumped download byte with its target address
	typedef struct packed {
		logic [`MIST_IOCTL_AW-1:0] addr;
		logic [7:0]                data;
	} dl_word_t;

endpackage

// File: rtl/mist_io_settings.svh
`ifndef MIST_IO_SETTINGS_SVH
`define MIST_IO_SETTINGS_SVH

// length of the core configuration string in bytes
`define MIST_CONF_STRLEN 12

// flat width of the configuration string port
`define MIST_CONF_W (8 * `MIST_CONF_STRLEN)

// reply byte for the acknowledge command, letter K
`define MIST_ACK_BYTE 8'h4b

// ioctl address width
`define MIST_IOCTL_AW 25

// every download starts here, boot rom area
`define MIST_DL_BASE_ADDR 25'h150000

// status word width, filled in four bytes
`define MIST_STATUS_W 32

// reply byte counter width, saturates well past the string
`define MIST_BYTE_CNT_W 10

// data byte index within one frame, saturates after the status bytes
`define MIST_DATA_IDX_W 3
`define MIST_DATA_IDX_MAX 3'd4

`endif

// File: rtl/spi_frame_rx.sv
`timescale 1ns/1ps

`include "mist_io_settings.svh"

module spi_frame_rx (
	input  logic                   SPI_SCK,
	input  logic                   SPI_SS2,
	input  logic                   SPI_DI,
	output mist_io_pkg::spi_byte_t rx_byte
);

	// counts 0-7 for the command byte, then 8-15 over and over
	logic [3:0] bit_cnt;

	// first seven bits of the byte in flight
	logic [6:0] sbuf;

	// frame select clears the bit position
	always_ff @(posedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2) begin
			bit_cnt <= 4'd0;
		end else begin
			if (bit_cnt == 4'd15) begin
				// wrap back to the data byte range
				bit_cnt <= 4'd8;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// msb first shift in
	// stale bits are pushed out before the next byte completes
	always_ff @(posedge SPI_SCK) begin
		sbuf <= {sbuf[5:0], SPI_DI};
	end

	// last bit goes straight in from the pin
	// so the byte is usable on the edge that completes it
	always_comb begin
		rx_byte.strb   = (bit_cnt[2:0] == 3'd7);
		// upper half of the count means a data byte
		rx_byte.is_cmd = ~bit_cnt[3];
		rx_byte.data   = {sbuf, SPI_DI};
	end

endmodule

// File: rtl/spi_reply_tx.sv
`timescale 1ns/1ps

`include "mist_io_settings.svh"

module spi_reply_tx (
	input  logic                   SPI_SCK,
	input  logic                   SPI_SS2,
	input  mist_io_pkg::io_cmd_e   cmd,
	input  logic [7:0]             data_in,
	input  logic [`MIST_CONF_W-1:0] conf_str,
	output logic                   SPI_DO
);

	// bit position of the next output bit, 0 is the msb
	// starts at 1, the first falling edge already falls inside byte 0
	logic [2:0] bit_q;
	// byte being sent, saturates
	logic [`MIST_BYTE_CNT_W-1:0] byte_q;

	logic do_q;
	// line is driven from the first falling edge of a frame on
	logic oe_q;

	logic [7:0] reply_byte;
	// low when the command has no reply
	logic       reply_en;

	always_comb begin
		reply_byte = 8'h00;
		reply_en   = 1'b1;
		case (cmd)
			mist_io_pkg::CMD_ACK:       reply_byte = `MIST_ACK_BYTE;
			mist_io_pkg::CMD_READ_DATA: reply_byte = data_in;
			mist_io_pkg::CMD_CONF_STR: begin
				// data byte k returns string byte k-1 from the top end
				if ((byte_q != '0) && (byte_q <= `MIST_CONF_STRLEN)) begin
					reply_byte = conf_str[8*(`MIST_CONF_STRLEN - byte_q) +: 8];
				end
			end
			default:                    reply_en = 1'b0;
		endcase
	end

	// mode 0, master samples on the rising edge
	always_ff @(negedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2) begin
			bit_q  <= 3'd1;
			byte_q <= '0;
			do_q   <= 1'b0;
			oe_q   <= 1'b0;
		end else begin
			oe_q <= 1'b1;
			// other commands keep the line where it was
			if (reply_en) begin
				do_q <= reply_byte[~bit_q];
			end
			bit_q <= bit_q + 3'd1;
			if ((bit_q == 3'd7) && (byte_q != '1)) begin
				byte_q <= byte_q + 1'b1;
			end
		end
	end

	assign SPI_DO = oe_q ? do_q : 1'bz;

endmodule
